//--- logic/aes_pkg.sv
package aes_pkg;

    localparam int block_bits = 128;
    localparam int key_bits   = 256;
    localparam int num_rounds = 14;

    // Byte i is FIPS-197 byte i and sits at bits 8i upward.
    typedef union packed {
        logic [block_bits-1:0]          word;
        logic [block_bits/8-1:0][7:0]   bytes;
    } block_u;

    // Forward S-box, entry 0 first.
    localparam logic [0:255][7:0] sbox_table = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] sbox(input logic [7:0] b);
        return sbox_table[b];
    endfunction

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1.
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

endpackage

//--- logic/stream_pkg.sv
package stream_pkg;

    localparam int word_bits   = 64;
    localparam int key_words   = 4;
    localparam int block_words = 2;

    // Frame phases of the input loader.
    typedef enum logic [3:0] {
        st_key     = 4'b0001,
        st_counter = 4'b0010,
        st_text    = 4'b0100,
        st_drain   = 4'b1000
    } loader_state_t;

endpackage

//--- logic/aes_round.sv
module aes_round (
    input  aes_pkg::block_u block_in,
    input  aes_pkg::block_u round_key,
    input  logic            final_round,
    output aes_pkg::block_u block_out
);

    aes_pkg::block_u sub_bytes;
    aes_pkg::block_u shifted;
    aes_pkg::block_u mixed;

    always_comb begin
        for (int i = 0; i < aes_pkg::block_bits / 8; i++)
            sub_bytes.bytes[i] = aes_pkg::sbox(block_in.bytes[i]);
    end

    // Row r of column c comes from column c+r.
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++)
                shifted.bytes[4*c + r] = sub_bytes.bytes[4*((c + r) % 4) + r];
        end
    end

    // Each output byte is 2a ^ 3b ^ c ^ d over its column.
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                mixed.bytes[4*c + r] = aes_pkg::xtime(shifted.bytes[4*c + r])
                                     ^ aes_pkg::xtime(shifted.bytes[4*c + (r + 1) % 4])
                                     ^ shifted.bytes[4*c + (r + 1) % 4]
                                     ^ shifted.bytes[4*c + (r + 2) % 4]
                                     ^ shifted.bytes[4*c + (r + 3) % 4];
            end
        end
    end

    assign block_out.word = (final_round ? shifted.word : mixed.word) ^ round_key.word;

endmodule

//--- logic/key_schedule.sv
module key_schedule (
    input  logic                         Clk,
    input  logic                         rst_n,
    input  logic [aes_pkg::key_bits-1:0] key,
    input  logic                         key_load,
    output aes_pkg::block_u              round_keys [aes_pkg::num_rounds-1],
    output logic                         schedule_ready
);

    logic [3:0] settle_cnt;

    // Register i holds round key i+2.
    for (genvar i = 0; i < aes_pkg::num_rounds - 1; i++) begin : g_step
        aes_pkg::block_u older;
        aes_pkg::block_u newer;
        aes_pkg::block_u next_key;
        logic [3:0][7:0] temp;

        if (i == 0) begin : g_from_key
            assign older.word = key[aes_pkg::block_bits-1:0];
            assign newer.word = key[aes_pkg::key_bits-1:aes_pkg::block_bits];
        end else if (i == 1) begin : g_from_mixed
            assign older.word = key[aes_pkg::key_bits-1:aes_pkg::block_bits];
            assign newer      = round_keys[0];
        end else begin : g_from_chain
            assign older = round_keys[i-2];
            assign newer = round_keys[i-1];
        end

        // Even steps rotate the last word and add the round constant.
        always_comb begin
            for (int b = 0; b < 4; b++)
                temp[b] = aes_pkg::sbox(newer.bytes[12 + (b + 1 - i % 2) % 4]);
            if (i % 2 == 0)
                temp[0] = temp[0] ^ (8'h01 << (i / 2));
        end

        always_comb begin
            next_key.word[31:0] = older.word[31:0] ^ temp;
            for (int w = 1; w < 4; w++) begin
                next_key.word[32*w +: 32] = older.word[32*w +: 32]
                                          ^ next_key.word[32*(w - 1) +: 32];
            end
        end

        always_ff @(posedge Clk) begin
            round_keys[i] <= next_key;
        end
    end

    // One register per cycle settles after a new key.
    always_ff @(posedge Clk) begin
        if (!rst_n)
            settle_cnt <= '0;
        else if (key_load)
            settle_cnt <= 4'(aes_pkg::num_rounds - 1);
        else if (settle_cnt != 0)
            settle_cnt <= settle_cnt - 1'b1;
    end

    assign schedule_ready = (settle_cnt == 0);

endmodule

//--- logic/ctr_loader.sv
module ctr_loader (
    input  logic                             Clk,
    input  logic                             rst_n,
    input  logic                             s_valid,
    output logic                             s_ready,
    input  logic [stream_pkg::word_bits-1:0] s_data,
    input  logic                             s_last,
    output logic [aes_pkg::key_bits-1:0]     key,
    output logic                             key_load,
    input  logic                             schedule_ready,
    output logic                             blk_valid,
    input  logic                             blk_ready,
    output aes_pkg::block_u                  blk_counter,
    output aes_pkg::block_u                  blk_text,
    output logic                             blk_last,
    input  logic                             frame_done
);

    stream_pkg::loader_state_t                state;
    stream_pkg::loader_state_t                next_state;
    logic [$clog2(stream_pkg::key_words)-1:0] word_cnt;
    logic                                     word_wrap;
    logic                                     s_fire;
    logic                                     text_fire;
    logic                                     blk_fire;
    logic [stream_pkg::word_bits-1:0]         data_swapped;
    aes_pkg::block_u                          counter;

    assign s_fire    = s_valid & s_ready;
    assign text_fire = s_fire & (state == stream_pkg::st_text);
    assign blk_fire  = blk_valid & blk_ready;
    assign word_wrap = (state == stream_pkg::st_key) ?
                       (word_cnt == stream_pkg::key_words - 1) :
                       (word_cnt == stream_pkg::block_words - 1);
    assign key_load  = s_fire & (state == stream_pkg::st_key) & word_wrap;

    always_ff @(posedge Clk) begin
        if (!rst_n)
            state <= stream_pkg::st_key;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            stream_pkg::st_key:
                if (s_fire && word_wrap) next_state = stream_pkg::st_counter;
            stream_pkg::st_counter:
                if (s_fire && word_wrap) next_state = stream_pkg::st_text;
            stream_pkg::st_text:
                if (s_fire && s_last) next_state = stream_pkg::st_drain;
            stream_pkg::st_drain:
                if (frame_done) next_state = stream_pkg::st_key;
            default:
                next_state = stream_pkg::st_key;
        endcase
    end

    // Text waits for a free pipeline slot and a settled key chain.
    always_comb begin
        case (state)
            stream_pkg::st_key, stream_pkg::st_counter:
                s_ready = 1'b1;
            stream_pkg::st_text:
                s_ready = schedule_ready & ~(blk_valid & ~blk_ready);
            default:
                s_ready = 1'b0;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rst_n)
            word_cnt <= '0;
        else if (s_fire) begin
            if (word_wrap || (state == stream_pkg::st_text && s_last))
                word_cnt <= '0;
            else
                word_cnt <= word_cnt + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (s_fire && state == stream_pkg::st_key)
            key[word_cnt*stream_pkg::word_bits +: stream_pkg::word_bits] <= s_data;
    end

    always_comb begin
        for (int i = 0; i < stream_pkg::word_bits / 8; i++)
            data_swapped[8*i +: 8] = s_data[stream_pkg::word_bits - 8 - 8*i +: 8];
    end

    // Counter is kept as a number. The first word lands in the top half.
    always_ff @(posedge Clk) begin
        if (s_fire && state == stream_pkg::st_counter)
            counter.word <= {counter.word[stream_pkg::word_bits-1:0], data_swapped};
        else if (blk_fire)
            counter.word <= counter.word + 1'b1;
    end

    always_comb begin
        for (int i = 0; i < aes_pkg::block_bits / 8; i++)
            blk_counter.bytes[i] = counter.bytes[aes_pkg::block_bits / 8 - 1 - i];
    end

    always_ff @(posedge Clk) begin
        if (text_fire) begin
            if (word_cnt == 0)
                blk_text.word <= {{stream_pkg::word_bits{1'b0}}, s_data};  // Zero slot 1.
            else
                blk_text.word[aes_pkg::block_bits-1:stream_pkg::word_bits] <= s_data;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            blk_valid <= 1'b0;
            blk_last  <= 1'b0;
        end else begin
            if (text_fire)
                blk_last <= s_last;
            if (text_fire && (word_wrap || s_last))
                blk_valid <= 1'b1;
            else if (blk_fire)
                blk_valid <= 1'b0;
        end
    end

endmodule

//--- logic/round_pipeline.sv
module round_pipeline (
    input  logic                         Clk,
    input  logic                         rst_n,
    input  aes_pkg::block_u              round_keys [aes_pkg::num_rounds-1],
    input  logic [aes_pkg::key_bits-1:0] key,
    input  logic                         blk_valid,
    output logic                         blk_ready,
    input  aes_pkg::block_u              blk_counter,
    input  aes_pkg::block_u              blk_text,
    input  logic                         blk_last,
    output logic                         out_valid,
    input  logic                         out_ready,
    output aes_pkg::block_u              out_stream,
    output aes_pkg::block_u              out_text,
    output logic                         out_last
);

    logic [aes_pkg::num_rounds-1:0] stage_valid;
    logic [aes_pkg::num_rounds-1:0] stage_last;
    logic [aes_pkg::num_rounds:0]   take;
    aes_pkg::block_u                stage_stream [aes_pkg::num_rounds];
    aes_pkg::block_u                stage_text [aes_pkg::num_rounds];

    assign take[aes_pkg::num_rounds] = out_ready;
    assign blk_ready = take[0];

    for (genvar i = 0; i < aes_pkg::num_rounds; i++) begin : g_stage
        aes_pkg::block_u round_in;
        aes_pkg::block_u round_key;
        aes_pkg::block_u round_out;
        logic            in_valid;
        aes_pkg::block_u in_text;
        logic            in_last;

        if (i == 0) begin : g_first
            // Whitening with the low key half, then round 1.
            assign round_in.word  = blk_counter.word ^ key[aes_pkg::block_bits-1:0];
            assign round_key.word = key[aes_pkg::key_bits-1:aes_pkg::block_bits];
            assign in_valid       = blk_valid;
            assign in_text        = blk_text;
            assign in_last        = blk_last;
        end else begin : g_next
            assign round_in  = stage_stream[i-1];
            assign round_key = round_keys[i-1];
            assign in_valid  = stage_valid[i-1];
            assign in_text   = stage_text[i-1];
            assign in_last   = stage_last[i-1];
        end

        assign take[i] = ~stage_valid[i] | take[i+1];  // Bubbles close up.

        aes_round u_round (
            .block_in    (round_in),
            .round_key   (round_key),
            .final_round (i == aes_pkg::num_rounds - 1),
            .block_out   (round_out)
        );

        always_ff @(posedge Clk) begin
            if (!rst_n) begin
                stage_valid[i] <= 1'b0;
                stage_last[i]  <= 1'b0;
            end else if (take[i]) begin
                stage_valid[i] <= in_valid;
                stage_last[i]  <= in_last;
            end
        end

        always_ff @(posedge Clk) begin
            if (take[i] && in_valid) begin
                stage_stream[i] <= round_out;
                stage_text[i]   <= in_text;
            end
        end
    end

    assign out_valid  = stage_valid[aes_pkg::num_rounds-1];
    assign out_stream = stage_stream[aes_pkg::num_rounds-1];
    assign out_text   = stage_text[aes_pkg::num_rounds-1];
    assign out_last   = stage_last[aes_pkg::num_rounds-1];

endmodule

//--- logic/block_serializer.sv
module block_serializer (
    input  logic                             Clk,
    input  logic                             rst_n,
    input  logic                             out_valid,
    output logic                             out_ready,
    input  aes_pkg::block_u                  out_stream,
    input  aes_pkg::block_u                  out_text,
    input  logic                             out_last,
    output logic                             m_valid,
    input  logic                             m_ready,
    output logic [stream_pkg::word_bits-1:0] m_data,
    output logic                             m_last,
    output logic                             frame_done
);

    logic [$clog2(stream_pkg::block_words)-1:0] word_sel;
    logic [aes_pkg::block_bits-1:0]             result;
    logic                                       m_fire;
    logic                                       last_word;

    assign result    = out_stream.word ^ out_text.word;
    assign m_valid   = out_valid;
    assign m_fire    = m_valid & m_ready;
    assign last_word = (word_sel == stream_pkg::block_words - 1);
    assign m_data    = result[word_sel*stream_pkg::word_bits +: stream_pkg::word_bits];
    assign m_last    = out_last & last_word;
    assign out_ready = m_fire & last_word;  // Block leaves with its second word.
    assign frame_done = m_fire & m_last;

    always_ff @(posedge Clk) begin
        if (!rst_n)
            word_sel <= '0;
        else if (m_fire)
            word_sel <= last_word ? '0 : word_sel + 1'b1;
    end

endmodule

//--- logic/aes256_ctr_top.sv
module aes256_ctr_top (
    input  logic                             Clk,
    input  logic                             rst_n,
    input  logic                             s_valid,
    output logic                             s_ready,
    input  logic [stream_pkg::word_bits-1:0] s_data,
    input  logic                             s_last,
    output logic                             m_valid,
    input  logic                             m_ready,
    output logic [stream_pkg::word_bits-1:0] m_data,
    output logic                             m_last
);

    logic [aes_pkg::key_bits-1:0] key;
    logic                         key_load;
    logic                         schedule_ready;
    aes_pkg::block_u              round_keys [aes_pkg::num_rounds-1];
    logic                         blk_valid;
    logic                         blk_ready;
    aes_pkg::block_u              blk_counter;
    aes_pkg::block_u              blk_text;
    logic                         blk_last;
    logic                         out_valid;
    logic                         out_ready;
    aes_pkg::block_u              out_stream;
    aes_pkg::block_u              out_text;
    logic                         out_last;
    logic                         frame_done;

    ctr_loader u_loader (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .s_valid        (s_valid),
        .s_ready        (s_ready),
        .s_data         (s_data),
        .s_last         (s_last),
        .key            (key),
        .key_load       (key_load),
        .schedule_ready (schedule_ready),
        .blk_valid      (blk_valid),
        .blk_ready      (blk_ready),
        .blk_counter    (blk_counter),
        .blk_text       (blk_text),
        .blk_last       (blk_last),
        .frame_done     (frame_done)
    );

    key_schedule u_schedule (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .key            (key),
        .key_load       (key_load),
        .round_keys     (round_keys),
        .schedule_ready (schedule_ready)
    );

    round_pipeline u_pipeline (
        .Clk         (Clk),
        .rst_n       (rst_n),
        .round_keys  (round_keys),
        .key         (key),
        .blk_valid   (blk_valid),
        .blk_ready   (blk_ready),
        .blk_counter (blk_counter),
        .blk_text    (blk_text),
        .blk_last    (blk_last),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_stream  (out_stream),
        .out_text    (out_text),
        .out_last    (out_last)
    );

    block_serializer u_serializer (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_stream (out_stream),
        .out_text   (out_text),
        .out_last   (out_last),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .m_data     (m_data),
        .m_last     (m_last),
        .frame_done (frame_done)
    );

endmodule

//--- tb/tb_aes256_ctr.sv
module tb_aes256_ctr;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 3000;

    // FIPS-197 AES-256 example key and block.
    localparam logic [63:0] kat_key [4] = '{64'h0706050403020100, 64'h0f0e0d0c0b0a0908,
                                            64'h1716151413121110, 64'h1f1e1d1c1b1a1918};
    localparam logic [63:0] kat_ctr [2] = '{64'h7766554433221100, 64'hffeeddccbbaa9988};

    logic        Clk;
    logic        rst_n;
    logic        s_valid;
    logic        s_ready;
    logic [63:0] s_data;
    logic        s_last;
    logic        m_valid;
    logic        m_ready;
    logic [63:0] m_data;
    logic        m_last;

    logic [63:0] in_mem [16];
    logic [63:0] exp_mem [16];
    logic [63:0] got_mem [16];
    logic [63:0] saved_a [16];
    logic [63:0] saved_b [16];
    int          out_total = 0;
    int          out_base = 0;
    int          out_idx;
    int          exp_count = 0;
    int          checked = 0;
    int          fail_count = 0;
    int          cycle_count = 0;
    int          hold_left = 0;
    logic        check_data = 1'b0;
    logic        bp_mode = 1'b0;
    logic        draining = 1'b0;
    logic [63:0] exp_data;
    logic        exp_last;

    aes256_ctr_top uut (
        .Clk     (Clk),
        .rst_n   (rst_n),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_data  (s_data),
        .s_last  (s_last),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_data  (m_data),
        .m_last  (m_last)
    );

    assign out_idx  = out_total - out_base;
    assign exp_data = exp_mem[out_idx[3:0]];
    assign exp_last = (out_idx == exp_count - 1);

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    function automatic void report_value(input string name, input logic [63:0] got,
                                         input logic [63:0] expected);
        fail_count++;
        $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
    endfunction

    function automatic void report_error(input string what);
        fail_count++;
        $display("Error at %0t: %s", $time, what);
    endfunction

    a_data: assert property (@(posedge Clk) disable iff (!rst_n)
        (m_valid && m_ready && check_data) |-> (m_data == exp_data))
        else report_value("m_data", $sampled(m_data), $sampled(exp_data));

    a_last: assert property (@(posedge Clk) disable iff (!rst_n)
        (m_valid && m_ready) |-> (m_last == exp_last))
        else report_value("m_last", 64'($sampled(m_last)), 64'($sampled(exp_last)));

    a_extra: assert property (@(posedge Clk) disable iff (!rst_n)
        m_valid |-> (out_idx < exp_count))
        else report_error("output word offered beyond the end of the frame");

    a_hold: assert property (@(posedge Clk) disable iff (!rst_n)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_last)))
        else report_error("output word changed or vanished while stalled");

    a_reset: assert property (@(posedge Clk) $rose(rst_n) |-> (!m_valid && s_ready))
        else report_error("m_valid or s_ready wrong right after reset");

    a_drain: assert property (@(posedge Clk) disable iff (!rst_n) draining |-> !s_ready)
        else report_error("s_ready rose before the frame's last output word");

    // Output handshakes and the drain window.
    always @(posedge Clk) begin
        if (m_valid && m_ready) begin
            got_mem[out_idx[3:0]] <= m_data;
            out_total <= out_total + 1;
            checked <= checked + 1;
        end
        if (!rst_n)
            draining <= 1'b0;
        else if (m_valid && m_ready && m_last)
            draining <= 1'b0;
        else if (s_valid && s_ready && s_last)
            draining <= 1'b1;
    end

    // Random m_ready with one long stall once output starts.
    always @(posedge Clk) begin
        #1;
        if (!bp_mode) begin
            m_ready = 1'b1;
            hold_left = 25;
        end else if (m_valid && hold_left > 0) begin
            m_ready = 1'b0;
            hold_left = hold_left - 1;
        end else
            m_ready = ($urandom() & 32'h1) != 0;
    end

    always @(posedge Clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (4) @(posedge Clk);
        #1;
        rst_n = 1'b1;
    endtask

    // Ready is sampled mid-cycle, the word moves on the next edge.
    task automatic send_word(input logic [63:0] data, input logic last);
        logic accepted;
        accepted = 1'b0;
        s_valid = 1'b1;
        s_data = data;
        s_last = last;
        while (!accepted) begin
            @(negedge Clk);
            accepted = s_ready;
            @(posedge Clk);
            #1;
        end
        s_valid = 1'b0;
        s_last = 1'b0;
    endtask

    task automatic run_frame(input int n, input logic check);
        out_base = out_total;
        exp_count = ((n + 1) / 2) * 2;
        check_data = check;
        for (int k = 0; k < 4; k++)
            send_word(kat_key[k], 1'b0);
        for (int c = 0; c < 2; c++)
            send_word(kat_ctr[c], 1'b0);
        for (int i = 0; i < n; i++)
            send_word(in_mem[i], i == n - 1);
        while (out_idx < exp_count) begin
            @(posedge Clk);
            #1;
        end
    endtask

    task automatic finish_test(input int num, input string name, input int fails_before);
        $display("test %0d %s: %0d errors", num, name, fail_count - fails_before);
    endtask

    initial begin
        int fails_before;
        rst_n = 1'b0;
        s_valid = 1'b0;
        s_data = '0;
        s_last = 1'b0;
        m_ready = 1'b1;
        void'($urandom(32'h7b9744f5));
        apply_reset();

        fails_before = fail_count;
        in_mem[0] = '0;
        in_mem[1] = '0;
        exp_mem[0] = 64'hbf456751cab7a28e;
        exp_mem[1] = 64'h8960494b9049fcea;
        run_frame(2, 1'b1);
        finish_test(1, "known answer", fails_before);

        fails_before = fail_count;
        for (int i = 0; i < 6; i++) begin
            in_mem[i] = {$urandom(), $urandom()};
            saved_a[i] = in_mem[i];
        end
        run_frame(6, 1'b0);
        // Each block needs a fresh counter value.
        for (int b = 1; b < 3; b++) begin
            assert ((got_mem[2*b] ^ saved_a[2*b]) != (got_mem[0] ^ saved_a[0]))
                else report_error("keystream repeated, the counter did not advance");
        end
        for (int i = 0; i < 6; i++) begin
            saved_b[i] = got_mem[i];
            in_mem[i] = got_mem[i];
            exp_mem[i] = saved_a[i];
        end
        run_frame(6, 1'b1);  // Decrypts back to the text.
        finish_test(2, "round trip", fails_before);

        fails_before = fail_count;
        for (int i = 0; i < 4; i++)
            in_mem[i] = {$urandom(), $urandom()};
        run_frame(4, 1'b0);
        for (int i = 0; i < 4; i++) begin
            exp_mem[i] = got_mem[i] ^ in_mem[i];
            in_mem[i] = {$urandom(), $urandom()};
            exp_mem[i] = exp_mem[i] ^ in_mem[i];
        end
        run_frame(4, 1'b1);
        finish_test(3, "linearity", fails_before);

        fails_before = fail_count;
        for (int i = 0; i < 6; i++) begin
            in_mem[i] = saved_a[i];
            exp_mem[i] = saved_b[i];
        end
        bp_mode = 1'b1;
        run_frame(6, 1'b1);
        bp_mode = 1'b0;
        finish_test(4, "back-pressure", fails_before);

        // Zero text gives the keystream of four words.
        fails_before = fail_count;
        apply_reset();
        for (int i = 0; i < 4; i++)
            in_mem[i] = '0;
        run_frame(4, 1'b0);
        for (int i = 0; i < 3; i++) begin
            in_mem[i] = {$urandom(), $urandom()};
            exp_mem[i] = in_mem[i] ^ got_mem[i];
        end
        exp_mem[3] = got_mem[3];
        run_frame(3, 1'b1);
        finish_test(5, "framing and reset", fails_before);

        $display("%0d output words checked, %0d errors", checked, fail_count);
        if (fail_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- build.f
logic/aes_pkg.sv
logic/stream_pkg.sv
logic/aes_round.sv
logic/key_schedule.sv
logic/ctr_loader.sv
logic/round_pipeline.sv
logic/block_serializer.sv
logic/aes256_ctr_top.sv
tb/tb_aes256_ctr.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
TOP       := tb_aes256_ctr
RTL_TOP   := aes256_ctr_top
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := ALL CHECKS PASSED

SOURCES   := $(shell cat $(FILELIST))
RTL_SRCS  := $(shell grep '^logic/' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
